// File: Bender.yml
package:
  name: conf_ctrl

sources:
  # shared package first
  - common/conf_pkg.sv

  # design
  - conf_reg/conf_reg_file.sv
  - conf_mem/conf_mem.sv
  - source/conf_ctrl.sv

  # testbench
  - target: simulation
    files:
      - dv/conf_ctrl_checker.sv
      - dv/conf_ctrl_tb.sv

// File: common/conf_pkg.sv
`default_nettype none

package conf_pkg;

   // control bus
   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   // functional unit counts
   localparam int N_ALU   = 2;
   localparam int N_MUL   = 2;
   localparam int N_BS    = 1;
   localparam int N_UNITS = N_ALU + N_MUL + N_BS;

   // unit index order on the bus is alu, mul, bs
   localparam int ALU_BASE = 0;
   localparam int MUL_BASE = ALU_BASE + N_ALU;
   localparam int BS_BASE  = MUL_BASE + N_MUL;

   // field widths
   localparam int SEL_W     = 5;
   localparam int ALU_FNS_W = 4;
   localparam int MUL_FNS_W = 2;
   localparam int BS_FNS_W  = 2;

   // address layout
   localparam int REGION_W = 2;
   localparam int UNIT_W   = 4;
   localparam int FIELD_W  = 2;
   localparam int MSLOT_W  = ADDR_W - REGION_W;

   localparam logic [REGION_W-1:0] REG_REGION = 2'd0;
   localparam logic [REGION_W-1:0] CMD_REGION = 2'd1;
   localparam logic [REGION_W-1:0] MEM_REGION = 2'd2;

   // command slot that wipes the bank
   localparam logic [MSLOT_W-1:0] CLEAR_SLOT = '0;

   localparam logic [FIELD_W-1:0] FIELD_SEL_A = 2'd0;
   localparam logic [FIELD_W-1:0] FIELD_SEL_B = 2'd1;
   localparam logic [FIELD_W-1:0] FIELD_FNS   = 2'd2;

   typedef struct packed {
      logic [SEL_W-1:0]     sel_a;
      logic [SEL_W-1:0]     sel_b;
      logic [ALU_FNS_W-1:0] fns;
   } alu_conf_t;

   typedef struct packed {
      logic [SEL_W-1:0]     sel_a;
      logic [SEL_W-1:0]     sel_b;
      logic [MUL_FNS_W-1:0] fns;
   } mul_conf_t;

   typedef struct packed {
      logic [SEL_W-1:0]    sel_data;
      logic [SEL_W-1:0]    sel_shift;
      logic [BS_FNS_W-1:0] fns;
   } bs_conf_t;

   // flat word to the data engine, also the memory slot format
   typedef struct packed {
      alu_conf_t [N_ALU-1:0] alu;
      mul_conf_t [N_MUL-1:0] mul;
      bs_conf_t  [N_BS-1:0]  bs;
   } conf_word_t;

   typedef struct packed {
      logic              valid;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } ctr_req_t;

   typedef struct packed {
      logic [REGION_W-1:0] region;
      logic [UNIT_W-1:0]   unit;
      logic [FIELD_W-1:0]  field;
   } reg_addr_t;

   typedef struct packed {
      logic [REGION_W-1:0] region;
      logic [MSLOT_W-1:0]  slot;
   } mem_addr_t;

   // same address byte, register view or memory/command view
   typedef union packed {
      reg_addr_t reg_v;
      mem_addr_t mem_v;
   } conf_addr_u;

endpackage

`default_nettype wire

// File: conf_mem/conf_mem.sv
`timescale 1ns/1ps
`default_nettype none

module conf_mem import conf_pkg::*; #(
   parameter int MEM_SLOTS = 16
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         save,
   input  logic                         load,
   input  logic [$clog2(MEM_SLOTS)-1:0] slot,
   input  conf_word_t                   conf_in,
   output conf_word_t                   ld_word,
   output logic                         ld_strobe
);

   conf_word_t mem_q [MEM_SLOTS];

   // slots start out empty so a load before any save gives zero
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < MEM_SLOTS; i++) begin
            mem_q[i] <= '0;
         end
      end else if (save) begin
         mem_q[slot] <= conf_in;
      end
   end

   // synchronous read, word valid together with the strobe
   always_ff @(posedge clk) begin
      if (load) begin
         ld_word <= mem_q[slot];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_strobe <= 1'b0;
      end else begin
         ld_strobe <= load;
      end
   end

endmodule

`default_nettype wire

// File: conf_reg/conf_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module conf_reg_file import conf_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              field_wr,
   input  logic [UNIT_W-1:0] unit,
   input  logic [FIELD_W-1:0] field,
   input  logic [DATA_W-1:0] wdata,
   input  logic              clear,
   input  logic              ld_strobe,
   input  conf_word_t        ld_word,
   output conf_word_t        conf_out
);

   conf_word_t conf_q;
   conf_word_t wr_word;

   // current word with the addressed field replaced
   always_comb begin
      wr_word = conf_q;

      for (int i = 0; i < N_ALU; i++) begin
         if (int'(unit) == ALU_BASE + i) begin
            case (field)
               FIELD_SEL_A: wr_word.alu[i].sel_a = wdata[SEL_W-1:0];
               FIELD_SEL_B: wr_word.alu[i].sel_b = wdata[SEL_W-1:0];
               FIELD_FNS:   wr_word.alu[i].fns   = wdata[ALU_FNS_W-1:0];
               default: ;
            endcase
         end
      end

      for (int i = 0; i < N_MUL; i++) begin
         if (int'(unit) == MUL_BASE + i) begin
            case (field)
               FIELD_SEL_A: wr_word.mul[i].sel_a = wdata[SEL_W-1:0];
               FIELD_SEL_B: wr_word.mul[i].sel_b = wdata[SEL_W-1:0];
               FIELD_FNS:   wr_word.mul[i].fns   = wdata[MUL_FNS_W-1:0];
               default: ;
            endcase
         end
      end

      // shifter: first select is the data input, second the shift amount
      for (int i = 0; i < N_BS; i++) begin
         if (int'(unit) == BS_BASE + i) begin
            case (field)
               FIELD_SEL_A: wr_word.bs[i].sel_data  = wdata[SEL_W-1:0];
               FIELD_SEL_B: wr_word.bs[i].sel_shift = wdata[SEL_W-1:0];
               FIELD_FNS:   wr_word.bs[i].fns       = wdata[BS_FNS_W-1:0];
               default: ;
            endcase
         end
      end
   end

   // memory load beats a bus write landing in the same cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         conf_q <= '0;
      end else if (ld_strobe) begin
         conf_q <= ld_word;
      end else if (clear) begin
         conf_q <= '0;
      end else if (field_wr) begin
         conf_q <= wr_word;
      end
   end

   assign conf_out = conf_q;

endmodule

`default_nettype wire

// File: dv/conf_ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module conf_ctrl_checker (
   input logic clk,
   input logic rst_n,
   input logic field_wr,
   input logic clear,
   input logic save,
   input logic load,
   input logic ld_strobe
);

   // read by the testbench at the end of the run
   int fail_count = 0;

   // a single load gives a single strobe cycle
   a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
      ld_strobe |=> !ld_strobe)
      else begin
         $error("ld_strobe high on two consecutive cycles");
         fail_count++;
      end

   a_load_to_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      load |=> ld_strobe)
      else begin
         $error("ld_strobe missing one cycle after load");
         fail_count++;
      end

   a_strobe_from_load: assert property (@(posedge clk) disable iff (!rst_n)
      ld_strobe |-> $past(load))
      else begin
         $error("ld_strobe without a load in the cycle before");
         fail_count++;
      end

   // decode gives at most one strobe per access
   a_decode_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({field_wr, clear, save, load}))
      else begin
         $error("more than one decode strobe high");
         fail_count++;
      end

   a_strobe_in_reset: assert property (@(posedge clk)
      !rst_n |=> !ld_strobe)
      else begin
         $error("ld_strobe high during reset");
         fail_count++;
      end

endmodule

`default_nettype wire

// File: dv/conf_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conf_ctrl_tb import conf_pkg::*; ();

   localparam int SLOTS      = 16;
   localparam int MAX_CYCLES = 4000;

   logic       clk;
   logic       rst_n;
   ctr_req_t   ctr;
   conf_word_t conf_out;

   conf_word_t model_word;
   conf_word_t model_slots [SLOTS];
   int         seed = 32'h4262_fb3a;
   int         cycles = 0;
   int         errors = 0;
   int         checks = 0;
   int         tests = 0;
   int         test_errors;
   string      test_name;
   int         saved_slots [6] = '{0, 3, 7, 9, 12, 15};

   conf_ctrl #(
      .MEM_SLOTS (SLOTS)
   ) i_conf_ctrl (
      .clk      (clk),
      .rst_n    (rst_n),
      .ctr      (ctr),
      .conf_out (conf_out)
   );

   bind conf_ctrl conf_ctrl_checker i_conf_ctrl_checker (
      .clk       (clk),
      .rst_n     (rst_n),
      .field_wr  (field_wr),
      .clear     (clear),
      .save      (save),
      .load      (load),
      .ld_strobe (ld_strobe)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [ADDR_W-1:0] field_addr(input int unit, input int fld);
      return {2'd0, unit[3:0], fld[1:0]};
   endfunction

   function automatic logic [ADDR_W-1:0] mem_addr(input int sl);
      return {2'd2, sl[5:0]};
   endfunction

   function automatic ctr_req_t make_req(input logic we, input logic [ADDR_W-1:0] addr,
                                         input logic [DATA_W-1:0] data);
      ctr_req_t req;
      req.valid = 1'b1;
      req.we    = we;
      req.addr  = addr;
      req.data  = data;
      return req;
   endfunction

   function automatic logic is_load(input ctr_req_t req);
      return req.valid && !req.we && req.addr[7:6] == 2'd2 && req.addr[5:0] < SLOTS;
   endfunction

   // reference model that applies one access and returns the expected word
   function automatic conf_word_t apply_access(input ctr_req_t req);
      logic [1:0] region;
      logic [3:0] unit;
      logic [1:0] fld;
      logic [5:0] sl;
      region = req.addr[7:6];
      unit   = req.addr[5:2];
      fld    = req.addr[1:0];
      sl     = req.addr[5:0];
      if (!req.valid) begin
         return model_word;
      end
      if (region == 2'd0 && req.we && fld != 2'd3) begin
         if (unit < 2) begin
            case (fld)
               2'd0: model_word.alu[unit].sel_a = req.data[SEL_W-1:0];
               2'd1: model_word.alu[unit].sel_b = req.data[SEL_W-1:0];
               default: model_word.alu[unit].fns = req.data[ALU_FNS_W-1:0];
            endcase
         end else if (unit < 4) begin
            case (fld)
               2'd0: model_word.mul[unit-2].sel_a = req.data[SEL_W-1:0];
               2'd1: model_word.mul[unit-2].sel_b = req.data[SEL_W-1:0];
               default: model_word.mul[unit-2].fns = req.data[MUL_FNS_W-1:0];
            endcase
         end else if (unit == 4) begin
            case (fld)
               2'd0: model_word.bs[0].sel_data = req.data[SEL_W-1:0];
               2'd1: model_word.bs[0].sel_shift = req.data[SEL_W-1:0];
               default: model_word.bs[0].fns = req.data[BS_FNS_W-1:0];
            endcase
         end
      end else if (region == 2'd1 && req.we && sl == 6'd0) begin
         model_word = '0;
      end else if (region == 2'd2 && sl < SLOTS) begin
         if (req.we) begin
            model_slots[sl] = model_word;
         end else begin
            model_word = model_slots[sl];
         end
      end
      return model_word;
   endfunction

   task automatic check_conf(input conf_word_t exp, input conf_word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         test_errors++;
         $display("MISMATCH %s: expected %h actual %h", test_name, exp, act);
      end
   endtask

   // starts on a falling edge and returns on the falling edge after the result is visible
   task automatic run_access(input ctr_req_t req);
      conf_word_t expected;
      ctr = req;
      expected = apply_access(req);
      @(negedge clk);
      ctr = '0;
      if (is_load(req)) begin
         @(negedge clk);
      end
      check_conf(expected, conf_out);
   endtask

   task automatic random_field_write();
      run_access(make_req(1'b1, field_addr(rand_below(5), rand_below(3)), $random(seed)));
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errors = 0;
      tests++;
   endtask

   task automatic finish_test();
      $display("test %s done: %0d errors", test_name, test_errors);
   endtask

   task automatic test_save_load();
      int pick;
      for (int k = 0; k < 6; k++) begin
         repeat (8) random_field_write();
         run_access(make_req(1'b1, mem_addr(saved_slots[k]), $random(seed)));
      end
      repeat (10) random_field_write();
      // load then write with no gap beyond the load latency
      for (int k = 0; k < 12; k++) begin
         pick = rand_below(6);
         run_access(make_req(1'b0, mem_addr(saved_slots[pick]), $random(seed)));
         random_field_write();
      end
   endtask

   task automatic test_unmapped();
      run_access(make_req(1'b1, {2'd3, 6'(rand_below(64))}, $random(seed)));
      run_access(make_req(1'b0, {2'd3, 6'(rand_below(64))}, $random(seed)));
      for (int u = 5; u < 16; u++) begin
         run_access(make_req(1'b1, field_addr(u, rand_below(3)), $random(seed)));
      end
      for (int u = 0; u < 5; u++) begin
         run_access(make_req(1'b1, field_addr(u, 3), $random(seed)));
         run_access(make_req(1'b0, field_addr(u, rand_below(3)), $random(seed)));
      end
      for (int s = 16; s < 64; s += 7) begin
         run_access(make_req(1'b1, mem_addr(s), $random(seed)));
         run_access(make_req(1'b0, mem_addr(s), $random(seed)));
      end
      for (int s = 1; s < 64; s += 5) begin
         run_access(make_req(1'b1, {2'd1, 6'(s)}, $random(seed)));
      end
      run_access(make_req(1'b0, {2'd1, 6'd0}, $random(seed)));
      for (int k = 0; k < 6; k++) begin
         run_access(make_req(1'b0, mem_addr(saved_slots[k]), $random(seed)));
      end
   endtask

   task automatic test_random_mix();
      ctr_req_t req;
      int       kind;
      for (int n = 0; n < 500; n++) begin
         kind = rand_below(8);
         if (kind < 4) begin
            req = make_req(1'b1, field_addr(rand_below(5), rand_below(3)), $random(seed));
         end else if (kind < 6) begin
            req = make_req(kind == 4, mem_addr(rand_below(SLOTS)), $random(seed));
         end else begin
            req = make_req(1'(rand_below(2)), ADDR_W'($random(seed)), $random(seed));
            req.valid = (kind == 6);
         end
         run_access(req);
      end
   endtask

   initial begin
      int chk_fails;
      clk = 1'b0;
      rst_n = 1'b0;
      ctr = '0;
      model_word = '0;
      for (int s = 0; s < SLOTS; s++) begin
         model_slots[s] = '0;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      start_test("reset_state");
      check_conf('0, conf_out);
      finish_test();

      start_test("field_writes");
      repeat (200) random_field_write();
      finish_test();

      start_test("clear_rebuild");
      run_access(make_req(1'b1, {2'd1, 6'd0}, $random(seed)));
      repeat (20) random_field_write();
      finish_test();

      start_test("save_load");
      test_save_load();
      finish_test();

      start_test("unmapped");
      test_unmapped();
      finish_test();

      start_test("random_mix");
      test_random_mix();
      finish_test();

      chk_fails = i_conf_ctrl.i_conf_ctrl_checker.fail_count;
      if (chk_fails > 0) begin
         $display("checker assertions failed %0d times", chk_fails);
      end
      $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               tests, checks, errors, chk_fails);
      if (errors == 0 && chk_fails == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/conf_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conf_ctrl import conf_pkg::*; #(
   parameter int MEM_SLOTS = 16
) (
   input  logic       clk,
   input  logic       rst_n,
   input  ctr_req_t   ctr,
   output conf_word_t conf_out
);

   localparam int SLOT_W = $clog2(MEM_SLOTS);

   conf_addr_u        addr;
   logic              acc_wr;
   logic              acc_rd;
   logic              unit_ok;
   logic              field_ok;
   logic              slot_ok;
   logic              field_wr;
   logic              clear;
   logic              save;
   logic              load;
   logic [SLOT_W-1:0] slot;
   logic              ld_strobe;
   conf_word_t        ld_word;

   assign addr   = ctr.addr;
   assign acc_wr = ctr.valid & ctr.we;
   assign acc_rd = ctr.valid & ~ctr.we;

   // range checks on the two address views
   assign unit_ok  = (int'(addr.reg_v.unit) < N_UNITS);
   assign field_ok = (addr.reg_v.field <= FIELD_FNS);
   assign slot_ok  = (int'(addr.mem_v.slot) < MEM_SLOTS);

   assign slot = addr.mem_v.slot[SLOT_W-1:0];

   // one strobe at most per access, region 3 falls through
   always_comb begin
      field_wr = 1'b0;
      clear    = 1'b0;
      save     = 1'b0;
      load     = 1'b0;
      case (addr.reg_v.region)
         REG_REGION: field_wr = acc_wr & unit_ok & field_ok;
         CMD_REGION: clear = acc_wr & (addr.mem_v.slot == CLEAR_SLOT);
         MEM_REGION: begin
            save = acc_wr & slot_ok;
            load = acc_rd & slot_ok;
         end
         default: ;
      endcase
   end

   conf_reg_file i_conf_reg_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .field_wr  (field_wr),
      .unit      (addr.reg_v.unit),
      .field     (addr.reg_v.field),
      .wdata     (ctr.data),
      .clear     (clear),
      .ld_strobe (ld_strobe),
      .ld_word   (ld_word),
      .conf_out  (conf_out)
   );

   conf_mem #(
      .MEM_SLOTS (MEM_SLOTS)
   ) i_conf_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .save      (save),
      .load      (load),
      .slot      (slot),
      .conf_in   (conf_out),
      .ld_word   (ld_word),
      .ld_strobe (ld_strobe)
   );

endmodule

`default_nettype wire

// File: src.f
common/conf_pkg.sv
conf_reg/conf_reg_file.sv
conf_mem/conf_mem.sv
source/conf_ctrl.sv
dv/conf_ctrl_checker.sv
dv/conf_ctrl_tb.sv
